/* Bender.yml */
package:
  name: soc_fabric

sources:
  - include_dirs:
      - .
    files:
      - soc_pkg.sv
      - axi_lite_if.sv
      - axi_xbar.sv
      - sram_slave.sv
      - clint_slave.sv
      - uart_slave.sv
      - soc_fabric_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - fabric_checker.sv
      - tb_soc_fabric.sv

/* axi_lite_if.sv */
`default_nettype none

`include "soc_settings.svh"

interface axi_r_if import soc_pkg::*; ();
  logic [`SOC_ADDR_W-1:0] araddr;
  logic                   arvalid;
  logic                   arready;
  logic [`SOC_DATA_W-1:0] rdata;
  axi_resp_e              rresp;
  logic                   rvalid;
  logic                   rready;

  modport master (
    output araddr, arvalid, rready,
    input  arready, rdata, rresp, rvalid
  );

  modport slave (
    input  araddr, arvalid, rready,
    output arready, rdata, rresp, rvalid
  );
endinterface

interface axi_w_if import soc_pkg::*; ();
  logic [`SOC_ADDR_W-1:0]   awaddr;
  logic                     awvalid;
  logic                     awready;
  logic [`SOC_DATA_W-1:0]   wdata;
  logic [`SOC_DATA_W/8-1:0] wstrb;
  logic                     wvalid;
  logic                     wready;
  axi_resp_e                bresp;
  logic                     bvalid;
  logic                     bready;

  modport master (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input  awready, wready, bresp, bvalid
  );

  modport slave (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output awready, wready, bresp, bvalid
  );
endinterface

`default_nettype wire

/* axi_xbar.sv */
`default_nettype none

`include "soc_settings.svh"

module axi_xbar import soc_pkg::*; (
  input  logic   clk,
  input  logic   rstn,
  axi_r_if.slave  cpu_r,
  axi_w_if.slave  cpu_w,
  axi_r_if.master sram_r,
  axi_w_if.master sram_w,
  axi_r_if.master clint_r,
  axi_w_if.master uart_w
);

  localparam logic [`SOC_ADDR_W-1:0] mtime_addr = `SOC_MTIME_ADDR;
  localparam logic [`SOC_ADDR_W-1:0] uart_addr  = `SOC_UART_ADDR;

  // ############################
  // read channel
  // ############################
  logic rd_hit_sram, rd_hit_clint;
  logic rd_sel_sram, rd_sel_clint, rd_err; // target of the read in flight
  logic rd_busy, rd_accept, rd_done;

  assign rd_hit_sram  = cpu_r.araddr[`SOC_ADDR_W-1 -: `SOC_SRAM_TAG_W] == `SOC_SRAM_TAG;
  assign rd_hit_clint = cpu_r.araddr[`SOC_ADDR_W-1:3] == mtime_addr[`SOC_ADDR_W-1:3];
  assign rd_busy      = rd_sel_sram | rd_sel_clint | rd_err;

  assign sram_r.araddr   = cpu_r.araddr;
  assign clint_r.araddr  = cpu_r.araddr;
  assign sram_r.arvalid  = !rd_busy & cpu_r.arvalid & rd_hit_sram;
  assign clint_r.arvalid = !rd_busy & cpu_r.arvalid & rd_hit_clint;

  always_comb begin
    if (rd_busy) cpu_r.arready = 1'b0;
    else if (rd_hit_sram) cpu_r.arready = sram_r.arready;
    else if (rd_hit_clint) cpu_r.arready = clint_r.arready;
    else cpu_r.arready = 1'b1; // unmapped, answered here
  end

  assign rd_accept = cpu_r.arvalid & cpu_r.arready;
  assign rd_done   = cpu_r.rvalid & cpu_r.rready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      rd_sel_sram  <= 1'b0;
      rd_sel_clint <= 1'b0;
      rd_err       <= 1'b0;
    end else if (rd_accept) begin
      rd_sel_sram  <= rd_hit_sram;
      rd_sel_clint <= rd_hit_clint;
      rd_err       <= !rd_hit_sram & !rd_hit_clint;
    end else if (rd_done) begin
      rd_sel_sram  <= 1'b0;
      rd_sel_clint <= 1'b0;
      rd_err       <= 1'b0;
    end
  end

  assign sram_r.rready  = rd_sel_sram & cpu_r.rready;
  assign clint_r.rready = rd_sel_clint & cpu_r.rready;

  always_comb begin
    cpu_r.rvalid = 1'b0;
    cpu_r.rdata  = '0;
    cpu_r.rresp  = OKAY;
    if (rd_sel_sram) begin
      cpu_r.rvalid = sram_r.rvalid;
      cpu_r.rdata  = sram_r.rdata;
      cpu_r.rresp  = sram_r.rresp;
    end else if (rd_sel_clint) begin
      cpu_r.rvalid = clint_r.rvalid;
      cpu_r.rdata  = clint_r.rdata;
      cpu_r.rresp  = clint_r.rresp;
    end else if (rd_err) begin
      cpu_r.rvalid = 1'b1;
      cpu_r.rresp  = DECERR;
    end
  end

  // ############################
  // write channel
  // ############################
  logic wr_hit_sram, wr_hit_uart;
  logic wr_sel_sram, wr_sel_uart, wr_err;
  logic wr_busy, wr_accept, wr_done;

  assign wr_hit_sram = cpu_w.awaddr[`SOC_ADDR_W-1 -: `SOC_SRAM_TAG_W] == `SOC_SRAM_TAG;
  assign wr_hit_uart = cpu_w.awaddr[`SOC_ADDR_W-1:2] == uart_addr[`SOC_ADDR_W-1:2];
  assign wr_busy     = wr_sel_sram | wr_sel_uart | wr_err;

  assign sram_w.awaddr  = cpu_w.awaddr;
  assign sram_w.wdata   = cpu_w.wdata;
  assign sram_w.wstrb   = cpu_w.wstrb;
  assign sram_w.awvalid = !wr_busy & cpu_w.awvalid & wr_hit_sram;
  assign sram_w.wvalid  = !wr_busy & cpu_w.wvalid & wr_hit_sram;
  assign uart_w.awaddr  = cpu_w.awaddr;
  assign uart_w.wdata   = cpu_w.wdata;
  assign uart_w.wstrb   = cpu_w.wstrb;
  assign uart_w.awvalid = !wr_busy & cpu_w.awvalid & wr_hit_uart;
  assign uart_w.wvalid  = !wr_busy & cpu_w.wvalid & wr_hit_uart;

  always_comb begin
    if (wr_busy) begin
      cpu_w.awready = 1'b0;
      cpu_w.wready  = 1'b0;
    end else if (wr_hit_sram) begin
      cpu_w.awready = sram_w.awready;
      cpu_w.wready  = sram_w.wready;
    end else if (wr_hit_uart) begin
      cpu_w.awready = uart_w.awready;
      cpu_w.wready  = uart_w.wready;
    end else begin
      cpu_w.awready = 1'b1;
      cpu_w.wready  = 1'b1;
    end
  end

  assign wr_accept = cpu_w.awvalid & cpu_w.awready & cpu_w.wvalid & cpu_w.wready;
  assign wr_done   = cpu_w.bvalid & cpu_w.bready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      wr_sel_sram <= 1'b0;
      wr_sel_uart <= 1'b0;
      wr_err      <= 1'b0;
    end else if (wr_accept) begin
      wr_sel_sram <= wr_hit_sram;
      wr_sel_uart <= wr_hit_uart;
      wr_err      <= !wr_hit_sram & !wr_hit_uart;
    end else if (wr_done) begin
      wr_sel_sram <= 1'b0;
      wr_sel_uart <= 1'b0;
      wr_err      <= 1'b0;
    end
  end

  assign sram_w.bready = wr_sel_sram & cpu_w.bready;
  assign uart_w.bready = wr_sel_uart & cpu_w.bready;

  always_comb begin
    cpu_w.bvalid = 1'b0;
    cpu_w.bresp  = OKAY;
    if (wr_sel_sram) begin
      cpu_w.bvalid = sram_w.bvalid;
      cpu_w.bresp  = sram_w.bresp;
    end else if (wr_sel_uart) begin
      cpu_w.bvalid = uart_w.bvalid;
      cpu_w.bresp  = uart_w.bresp;
    end else if (wr_err) begin
      cpu_w.bvalid = 1'b1;
      cpu_w.bresp  = DECERR;
    end
  end

  // ############################
  // checks
  // ############################
  a_one_rd_target: assert property (@(posedge clk) disable iff (rstn)
    $onehot0({sram_r.arvalid, clint_r.arvalid}));

  a_rd_in_flight: assert property (@(posedge clk) disable iff (rstn)
    rd_accept |=> !cpu_r.arready until_with (cpu_r.rvalid && cpu_r.rready));

endmodule

`default_nettype wire

/* clint_slave.sv */
`default_nettype none

module clint_slave import soc_pkg::*; (
  input  logic   clk,
  input  logic   rstn,
  axi_r_if.slave rd
);

  mtime_word_t mtime;
  logic        rd_accept;

  always_ff @(posedge clk) begin
    if (rstn) mtime.count <= '0;
    else mtime.count <= mtime.count + 64'd1; // one tick per cycle
  end

  assign rd.arready = !rd.rvalid;
  assign rd.rresp   = OKAY;
  assign rd_accept  = rd.arvalid & rd.arready;

  always_ff @(posedge clk) begin
    if (rd_accept) rd.rdata <= rd.araddr[2] ? mtime.half.hi : mtime.half.lo;
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      rd.rvalid <= 1'b0;
    end else if (rd_accept) begin
      rd.rvalid <= 1'b1;
    end else if (rd.rready) begin
      rd.rvalid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* fabric_checker.sv */
`default_nettype none

`include "soc_settings.svh"

module fabric_checker import soc_pkg::*; (
  input logic                   clk,
  input logic                   rstn,
  input logic [`SOC_DATA_W-1:0] rdata,
  input logic [1:0]             rresp,
  input logic                   rvalid,
  input logic                   rready,
  input logic [1:0]             bresp,
  input logic                   bvalid,
  input logic                   bready,
  input logic [7:0]             uart_data,
  input logic                   uart_strobe
);
  timeunit 1ns;
  timeprecision 1ps;

  int error_count;

  // expected responses, oldest first
  int                     rd_kind [$]; // 0 data, 1 mtime lo, 2 mtime hi
  logic [`SOC_DATA_W-1:0] rd_data [$];
  axi_resp_e              rd_resp [$];
  axi_resp_e              wr_resp [$];
  logic [7:0]             chars [$];

  logic [`SOC_DATA_W-1:0] mtime_lo;
  mtime_word_t            mtime_last;
  logic [63:0]            cycles; // clock cycles since reset
  logic                   r_held, b_held; // response stalled last cycle
  logic [`SOC_DATA_W-1:0] r_held_data;
  logic [1:0]             r_held_resp, b_held_resp;

  initial begin
    error_count      = 0;
    mtime_last.count = '0;
    cycles           = '0;
    r_held           = 1'b0;
    b_held           = 1'b0;
  end

  function automatic void read_expect(input logic [31:0] data, input logic [1:0] resp);
    rd_kind.push_back(0);
    rd_data.push_back(data);
    rd_resp.push_back(axi_resp_e'(resp));
  endfunction

  function automatic void mtime_expect(input logic hi);
    rd_kind.push_back(hi ? 2 : 1);
    rd_data.push_back('0);
    rd_resp.push_back(OKAY);
  endfunction

  function automatic void bresp_expect(input logic [1:0] resp);
    wr_resp.push_back(axi_resp_e'(resp));
  endfunction

  function automatic void char_expect(input logic [7:0] c);
    chars.push_back(c);
  endfunction

  function automatic int outstanding();
    return rd_kind.size() + wr_resp.size() + chars.size();
  endfunction

  // ##############################
  // response checks
  // ##############################
  task automatic read_check();
    int                     kind;
    logic [`SOC_DATA_W-1:0] data;
    axi_resp_e              resp;
    mtime_word_t            now;
    if (rd_kind.size() == 0) begin
      error_count++;
      $display("read response at %0t arrived with no read outstanding", $time);
      return;
    end
    kind = rd_kind.pop_front();
    data = rd_data.pop_front();
    resp = rd_resp.pop_front();
    if (rresp !== resp) begin
      error_count++;
      $display("mismatch at %0t: rresp %0d, expected %0d", $time, rresp, resp);
    end
    if (kind == 0 && rdata !== data) begin
      error_count++;
      $display("mismatch at %0t: rdata %h, expected %h", $time, rdata, data);
    end else if (kind == 1) begin
      mtime_lo = rdata;
    end else if (kind == 2) begin
      now.half.hi = rdata;
      now.half.lo = mtime_lo;
      if ($isunknown(now.count) || now.count <= mtime_last.count) begin
        error_count++;
        $display("mismatch at %0t: mtime %0d not above %0d", $time, now.count,
                 mtime_last.count);
      end else if (now.count > cycles) begin
        error_count++;
        $display("mismatch at %0t: mtime %0d exceeds %0d cycles since reset", $time,
                 now.count, cycles);
      end
      mtime_last = now;
    end
  endtask

  task automatic bresp_check();
    axi_resp_e resp;
    if (wr_resp.size() == 0) begin
      error_count++;
      $display("write response at %0t arrived with no write outstanding", $time);
      return;
    end
    resp = wr_resp.pop_front();
    if (bresp !== resp) begin
      error_count++;
      $display("mismatch at %0t: bresp %0d, expected %0d", $time, bresp, resp);
    end
  endtask

  task automatic char_check();
    logic [7:0] c;
    if (chars.size() == 0) begin
      error_count++;
      $display("uart strobe at %0t with no uart write pending", $time);
      return;
    end
    c = chars.pop_front();
    if (uart_data !== c) begin
      error_count++;
      $display("mismatch at %0t: uart_data %h, expected %h", $time, uart_data, c);
    end
  endtask

  task automatic hold_check();
    if (r_held && (!rvalid || rdata !== r_held_data || rresp !== r_held_resp)) begin
      error_count++;
      $display("mismatch at %0t: read response changed while rready low", $time);
    end
    if (b_held && (!bvalid || bresp !== b_held_resp)) begin
      error_count++;
      $display("mismatch at %0t: write response changed while bready low", $time);
    end
  endtask

  // mid-cycle sampling, a transfer happens at the next rising edge
  always @(negedge clk) begin
    if (rstn) begin
      if (rvalid !== 1'b0 || bvalid !== 1'b0 || uart_strobe !== 1'b0) begin
        error_count++;
        $display("mismatch at %0t: valid or strobe output high during reset", $time);
      end
      cycles = '0;
      r_held = 1'b0;
      b_held = 1'b0;
    end else begin
      cycles = cycles + 64'd1;
      hold_check();
      if (rvalid && rready) read_check();
      if (bvalid && bready) bresp_check();
      if (uart_strobe) char_check();
      r_held      = rvalid && !rready;
      r_held_data = rdata;
      r_held_resp = rresp;
      b_held      = bvalid && !bready;
      b_held_resp = bresp;
    end
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
soc_pkg.sv
axi_lite_if.sv
axi_xbar.sv
sram_slave.sv
clint_slave.sv
uart_slave.sv
soc_fabric_top.sv
fabric_checker.sv
tb_soc_fabric.sv

/* soc_fabric_top.sv */
`default_nettype none

`include "soc_settings.svh"

module soc_fabric_top (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic [`SOC_ADDR_W-1:0]   araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [`SOC_DATA_W-1:0]   rdata,
  output logic [1:0]               rresp,
  output logic                     rvalid,
  input  logic                     rready,
  input  logic [`SOC_ADDR_W-1:0]   awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [`SOC_DATA_W-1:0]   wdata,
  input  logic [`SOC_DATA_W/8-1:0] wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output logic [1:0]               bresp,
  output logic                     bvalid,
  input  logic                     bready,
  output logic [7:0]               uart_data,
  output logic                     uart_strobe
);

  axi_r_if cpu_r ();
  axi_w_if cpu_w ();
  axi_r_if sram_r ();
  axi_w_if sram_w ();
  axi_r_if clint_r ();
  axi_w_if uart_w ();

  // cpu side onto the bus
  assign cpu_r.araddr  = araddr;
  assign cpu_r.arvalid = arvalid;
  assign cpu_r.rready  = rready;
  assign arready       = cpu_r.arready;
  assign rdata         = cpu_r.rdata;
  assign rresp         = cpu_r.rresp;
  assign rvalid        = cpu_r.rvalid;

  assign cpu_w.awaddr  = awaddr;
  assign cpu_w.awvalid = awvalid;
  assign cpu_w.wdata   = wdata;
  assign cpu_w.wstrb   = wstrb;
  assign cpu_w.wvalid  = wvalid;
  assign cpu_w.bready  = bready;
  assign awready       = cpu_w.awready;
  assign wready        = cpu_w.wready;
  assign bresp         = cpu_w.bresp;
  assign bvalid        = cpu_w.bvalid;

  axi_xbar u_axi_xbar (
    .clk     (clk),
    .rstn    (rstn),
    .cpu_r   (cpu_r.slave),
    .cpu_w   (cpu_w.slave),
    .sram_r  (sram_r.master),
    .sram_w  (sram_w.master),
    .clint_r (clint_r.master),
    .uart_w  (uart_w.master)
  );

  sram_slave u_sram_slave (
    .clk  (clk),
    .rstn (rstn),
    .rd   (sram_r.slave),
    .wr   (sram_w.slave)
  );

  clint_slave u_clint_slave (
    .clk  (clk),
    .rstn (rstn),
    .rd   (clint_r.slave)
  );

  uart_slave u_uart_slave (
    .clk         (clk),
    .rstn        (rstn),
    .wr          (uart_w.slave),
    .uart_data   (uart_data),
    .uart_strobe (uart_strobe)
  );

endmodule

`default_nettype wire

/* soc_pkg.sv */
`default_nettype none

package soc_pkg;

  // bus response code
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    DECERR = 2'b11
  } axi_resp_e;

  // mtime seen as one count or as two bus words
  typedef union packed {
    logic [63:0] count;
    struct packed {
      logic [31:0] hi;
      logic [31:0] lo;
    } half;
  } mtime_word_t;

endpackage

`default_nettype wire

/* soc_settings.svh */
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// sram, 128 MB region at 0x8000_0000 folded onto the array
`define SOC_SRAM_DEPTH 1024
`define SOC_SRAM_TAG_W 5
`define SOC_SRAM_TAG 5'b10000

`define SOC_MTIME_ADDR 32'ha000_0048 // lo word, hi at +4
`define SOC_UART_ADDR 32'ha000_03f8 // tx data

`endif

/* soc_vectors.txt */
# op addr data strb exp_data resp, all hex; op w write, r read, m read against merged model,
# t mtime lo/hi pair, i idle cycles given in data; resp 0 okay, 3 decode error
w 80000010 cafef00d f 00000000 0
r 80000010 00000000 0 cafef00d 0
w 80000010 000000aa 1 00000000 0
w 80000010 55000000 8 00000000 0
m 80000010 00000000 0 00000000 0
r 80000010 00000000 0 55fef0aa 0
w 87ff0ffc 0badc0de f 00000000 0
w 87ff0ffc 00345600 6 00000000 0
m 87ff0ffc 00000000 0 00000000 0
r 80000ffc 00000000 0 0b3456de 0
t a0000048 00000000 0 00000000 0
t a0000048 00000000 0 00000000 0
i 00000000 00000014 0 00000000 0
t a0000048 00000000 0 00000000 0
w a00003f8 00000041 1 00000000 0
w a00003f8 12345642 f 00000000 0
w a00003f8 00000043 0 00000000 0
r 10000000 00000000 0 00000000 3
w 10000000 deadbeef f 00000000 3
r 00000004 00000000 0 00000000 3
w 80000020 a5a55a5a f 00000000 0
r 80000020 00000000 0 a5a55a5a 0
t a0000048 00000000 0 00000000 0

/* sram_slave.sv */
`default_nettype none

`include "soc_settings.svh"

module sram_slave import soc_pkg::*; (
  input  logic   clk,
  input  logic   rstn,
  axi_r_if.slave rd,
  axi_w_if.slave wr
);

  localparam int idx_w = $clog2(`SOC_SRAM_DEPTH);

  logic [`SOC_DATA_W-1:0] mem [`SOC_SRAM_DEPTH];
  logic [idx_w-1:0]       rd_idx, wr_idx;
  logic                   rd_accept, wr_accept;

  assign rd_idx = rd.araddr[idx_w+1:2]; // word index, region folds
  assign wr_idx = wr.awaddr[idx_w+1:2];

  // ready only with no response pending
  assign rd.arready = !rd.rvalid;
  assign wr.awready = !wr.bvalid;
  assign wr.wready  = !wr.bvalid;
  assign rd.rresp   = OKAY;
  assign wr.bresp   = OKAY;

  assign rd_accept = rd.arvalid & rd.arready;
  assign wr_accept = wr.awvalid & wr.awready & wr.wvalid & wr.wready;

  always_ff @(posedge clk) begin
    if (rd_accept) rd.rdata <= mem[rd_idx];
  end

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      for (int b = 0; b < `SOC_DATA_W/8; b++) begin
        if (wr.wstrb[b]) mem[wr_idx][8*b +: 8] <= wr.wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      rd.rvalid <= 1'b0;
      wr.bvalid <= 1'b0;
    end else begin
      if (rd_accept) rd.rvalid <= 1'b1;
      else if (rd.rready) rd.rvalid <= 1'b0;
      if (wr_accept) wr.bvalid <= 1'b1;
      else if (wr.bready) wr.bvalid <= 1'b0;
    end
  end

  a_rvalid_hold: assert property (@(posedge clk) disable iff (rstn)
    rd.rvalid && !rd.rready |=> rd.rvalid && $stable(rd.rdata));

endmodule

`default_nettype wire

/* tb_soc_fabric.sv */
`default_nettype none

`include "soc_settings.svh"

module tb_soc_fabric;
  timeunit 1ns;
  timeprecision 1ps;

  logic                     clk = 1'b0;
  logic                     rstn;
  logic [`SOC_ADDR_W-1:0]   araddr;
  logic                     arvalid;
  logic                     arready;
  logic [`SOC_DATA_W-1:0]   rdata;
  logic [1:0]               rresp;
  logic                     rvalid;
  logic                     rready;
  logic [`SOC_ADDR_W-1:0]   awaddr;
  logic                     awvalid;
  logic                     awready;
  logic [`SOC_DATA_W-1:0]   wdata;
  logic [`SOC_DATA_W/8-1:0] wstrb;
  logic                     wvalid;
  logic                     wready;
  logic [1:0]               bresp;
  logic                     bvalid;
  logic                     bready;
  logic [7:0]               uart_data;
  logic                     uart_strobe;

  // vector table, one entry per line of the file
  logic [7:0]               v_op [$];
  logic [`SOC_ADDR_W-1:0]   v_addr [$];
  logic [`SOC_DATA_W-1:0]   v_data [$];
  logic [`SOC_DATA_W/8-1:0] v_strb [$];
  logic [`SOC_DATA_W-1:0]   v_exp [$];
  logic [1:0]               v_resp [$];

  logic [`SOC_DATA_W-1:0]   shadow [int]; // sram words written so far
  integer                   seed;
  int                       tb_errors;
  bit                       loaded;

  soc_fabric_top u_soc_fabric_top (.*);

  fabric_checker u_fabric_checker (
    .clk         (clk),
    .rstn        (rstn),
    .rdata       (rdata),
    .rresp       (rresp),
    .rvalid      (rvalid),
    .rready      (rready),
    .bresp       (bresp),
    .bvalid      (bvalid),
    .bready      (bready),
    .uart_data   (uart_data),
    .uart_strobe (uart_strobe)
  );

  always #2 clk = ~clk;

  // random back-pressure on both response channels
  always @(posedge clk) begin
    #1;
    if (rstn) begin
      rready = 1'b0;
      bready = 1'b0;
    end else begin
      rready = ($random(seed) & 3) != 0; // low about one cycle in four
      bready = ($random(seed) & 3) != 0;
    end
  end

  function automatic logic is_sram(input logic [`SOC_ADDR_W-1:0] addr);
    return addr[`SOC_ADDR_W-1 -: `SOC_SRAM_TAG_W] == `SOC_SRAM_TAG;
  endfunction

  function automatic int word_index(input logic [`SOC_ADDR_W-1:0] addr);
    return int'(addr >> 2) % `SOC_SRAM_DEPTH; // region folds onto the array
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  task automatic load_vectors();
    int                     fd;
    int                     n;
    string                  line;
    logic [7:0]             op;
    logic [`SOC_ADDR_W-1:0] a;
    logic [`SOC_DATA_W-1:0] d, e;
    logic [3:0]             s;
    logic [1:0]             r;
    fd = $fopen("soc_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open soc_vectors.txt");
      tb_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
        n = $sscanf(line, "%c %h %h %h %h %h", op, a, d, s, e, r);
        if (n == 6) begin
          v_op.push_back(op);
          v_addr.push_back(a);
          v_data.push_back(d);
          v_strb.push_back(s);
          v_exp.push_back(e);
          v_resp.push_back(r);
        end else begin
          $display("unreadable vector line: %s", line);
          tb_errors++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic read_word(input logic [`SOC_ADDR_W-1:0] addr);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    next_cycle();
    arvalid = 1'b0;
  endtask

  task automatic write_word(input logic [`SOC_ADDR_W-1:0] addr,
                            input logic [`SOC_DATA_W-1:0] data, input logic [3:0] strb);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    next_cycle();
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic run_vector(input int i);
    logic [`SOC_ADDR_W-1:0] a;
    logic [`SOC_DATA_W-1:0] old;
    int                     idx;
    a   = v_addr[i];
    idx = word_index(a);
    case (v_op[i])
      "w": begin
        u_fabric_checker.bresp_expect(v_resp[i]);
        if (a == `SOC_UART_ADDR)
          u_fabric_checker.char_expect(v_strb[i][0] ? v_data[i][7:0] : 8'h00);
        if (is_sram(a)) begin
          old = shadow.exists(idx) ? shadow[idx] : 'x; // unwritten bytes stay unknown
          shadow[idx] = merge_bytes(old, v_data[i], v_strb[i]);
        end
        write_word(a, v_data[i], v_strb[i]);
      end
      "r": begin
        u_fabric_checker.read_expect(v_exp[i], v_resp[i]);
        read_word(a);
      end
      "m": begin
        if (!shadow.exists(idx)) begin
          $display("vector %0d reads an sram word that was never written", i);
          tb_errors++;
        end else begin
          u_fabric_checker.read_expect(shadow[idx], v_resp[i]);
          read_word(a);
        end
      end
      "t": begin
        u_fabric_checker.mtime_expect(1'b0);
        read_word(a);
        u_fabric_checker.mtime_expect(1'b1);
        read_word(a + 4);
      end
      "i": repeat (v_data[i]) next_cycle();
      default: begin
        $display("vector %0d has an unknown operation", i);
        tb_errors++;
      end
    endcase
  endtask

  initial begin
    seed      = 32'hde0e1698;
    tb_errors = 0;
    loaded    = 1'b0;
    rstn      = 1'b1;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    load_vectors();
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    #1 rstn = 1'b0;
    foreach (v_op[i]) run_vector(i);
    while (u_fabric_checker.outstanding() != 0) next_cycle();
    repeat (4) next_cycle();
    $display("%0d vectors, %0d checker errors, %0d testbench errors", v_op.size(),
             u_fabric_checker.error_count, tb_errors);
    if (u_fabric_checker.error_count + tb_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog, 200 cycles per vector
  initial begin
    wait (loaded);
    repeat ((v_op.size() + 1) * 200) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", (v_op.size() + 1) * 200);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* uart_slave.sv */
`default_nettype none

module uart_slave import soc_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  axi_w_if.slave     wr,
  output logic [7:0] uart_data,
  output logic       uart_strobe
);

  logic wr_accept;

  assign wr.awready = !wr.bvalid;
  assign wr.wready  = !wr.bvalid;
  assign wr.bresp   = OKAY;
  assign wr_accept  = wr.awvalid & wr.awready & wr.wvalid & wr.wready;

  // character goes out in the acceptance cycle
  assign uart_strobe = wr_accept;
  assign uart_data   = wr.wstrb[0] ? wr.wdata[7:0] : 8'h00;

  always_ff @(posedge clk) begin
    if (rstn) begin
      wr.bvalid <= 1'b0;
    end else if (wr_accept) begin
      wr.bvalid <= 1'b1;
    end else if (wr.bready) begin
      wr.bvalid <= 1'b0;
    end
  end

endmodule

`default_nettype wire
